// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_int_core
RTL_TOP   ?= int_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/1ns
RTL_SRCS  ?= $(filter src/%,$(shell cat $(FILELIST)))
SIM_SRCS  ?= $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SIM_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
	input  logic             clk,
	input  logic             reset_i,
	input  core_pkg::issue_t iss_i,
	output core_pkg::wb_t    fwd_o,
	output core_pkg::wb_t    wb_o
);
	import core_pkg::*;

	logic [SHAMT_W-1:0] shamt;
	xdata_t             result;

	assign shamt = iss_i.op_b[SHAMT_W-1:0];

	always_comb begin
		case (iss_i.alu_op)
			ALU_ADD: result = iss_i.op_a + iss_i.op_b;
			ALU_SUB: result = iss_i.op_a - iss_i.op_b;
			ALU_SLL: result = iss_i.op_a << shamt;
			ALU_SLT: begin
				result = {{(XLEN-1){1'b0}}, $signed(iss_i.op_a) < $signed(iss_i.op_b)};
			end
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, iss_i.op_a < iss_i.op_b};
			ALU_XOR: result = iss_i.op_a ^ iss_i.op_b;
			ALU_SRL: result = iss_i.op_a >> shamt;
			ALU_SRA: result = xdata_t'($signed(iss_i.op_a) >>> shamt);
			ALU_OR: result = iss_i.op_a | iss_i.op_b;
			ALU_AND: result = iss_i.op_a & iss_i.op_b;
			default: result = '0;
		endcase
		// illegal ops report zero
		if (iss_i.illegal) begin
			result = '0;
		end
	end

	always_comb begin
		fwd_o.valid = iss_i.valid;
		fwd_o.rd = iss_i.rd;
		fwd_o.value = result;
		fwd_o.rd_we = iss_i.rd_we;
		fwd_o.illegal = iss_i.illegal;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_o.valid <= 1'b0;
			wb_o.rd_we <= 1'b0;
			wb_o.illegal <= 1'b0;
		end else begin
			wb_o <= fwd_o;
		end
	end

	// valid must be clean all the way from the decoder
	assert property (@(posedge clk) disable iff (reset_i)
		!$isunknown(wb_o.valid));

endmodule

// File: src/core_pkg.sv
package core_pkg;

	localparam int XLEN = 64;
	localparam int REG_ADDR_W = 5;
	// shift amount width for RV64
	localparam int SHAMT_W = 6;

	typedef logic [XLEN-1:0] xdata_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_SLL = 4'd2;
	localparam alu_op_t ALU_SLT = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR = 4'd5;
	localparam alu_op_t ALU_SRL = 4'd6;
	localparam alu_op_t ALU_SRA = 4'd7;
	localparam alu_op_t ALU_OR = 4'd8;
	localparam alu_op_t ALU_AND = 4'd9;

	// major opcodes of the two kept groups
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	typedef struct packed {
		logic      valid;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      use_imm;
		xdata_t    imm;
		alu_op_t   alu_op;
		logic      rd_we;
		logic      illegal;
	} decoded_t;

	typedef struct packed {
		logic      valid;
		xdata_t    op_a;
		xdata_t    op_b;
		alu_op_t   alu_op;
		reg_addr_t rd;
		logic      rd_we;
		logic      illegal;
	} issue_t;

	// result bundle, also the bypass source
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		xdata_t    value;
		logic      rd_we;
		logic      illegal;
	} wb_t;

endpackage

// File: src/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               inst_valid_i,
	input  core_pkg::inst_t    inst_i,
	output core_pkg::decoded_t dec_o
);
	import core_pkg::*;

	logic       inst_valid_q;
	inst_t      inst_q;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;
	decoded_t   dec_d;

	// capture the strobe
	always_ff @(posedge clk) begin
		if (reset_i) begin
			inst_valid_q <= 1'b0;
		end else begin
			inst_valid_q <= inst_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			inst_q <= inst_i;
		end
	end

	assign opcode = inst_q[6:0];
	assign funct3 = inst_q[14:12];
	assign funct7 = inst_q[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			OPC_OP: begin
				// 0100000 only for sub and sra
				legal = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			OPC_OP_IMM: begin
				case (funct3)
					3'b001: legal = (inst_q[31:26] == 6'b000000);
					3'b101: legal = (inst_q[31:26] == 6'b000000) ||
						(inst_q[31:26] == 6'b010000);
					default: legal = 1'b1;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		dec_d.valid = inst_valid_q;
		dec_d.rs1 = inst_q[19:15];
		dec_d.rs2 = inst_q[24:20];
		dec_d.rd = inst_q[11:7];
		dec_d.use_imm = (opcode == OPC_OP_IMM);
		dec_d.imm = {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};
		case (funct3)
			// addi has no sub form, bit 30 is immediate there
			3'b000: dec_d.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001: dec_d.alu_op = ALU_SLL;
			3'b010: dec_d.alu_op = ALU_SLT;
			3'b011: dec_d.alu_op = ALU_SLTU;
			3'b100: dec_d.alu_op = ALU_XOR;
			3'b101: dec_d.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: dec_d.alu_op = ALU_OR;
			default: dec_d.alu_op = ALU_AND;
		endcase
		dec_d.illegal = inst_valid_q & ~legal;
		dec_d.rd_we = inst_valid_q & legal;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			dec_o.valid <= 1'b0;
			dec_o.rd_we <= 1'b0;
			dec_o.illegal <= 1'b0;
		end else begin
			dec_o <= dec_d;
		end
	end

	// illegal encodings never reach the register file
	assert property (@(posedge clk) disable iff (reset_i)
		dec_o.illegal |-> !dec_o.rd_we);

endmodule

// File: src/int_core.sv
`timescale 1ns/1ns

module int_core (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                inst_valid_i,
	input  core_pkg::inst_t     inst_i,
	output logic                result_valid_o,
	output core_pkg::reg_addr_t result_rd_o,
	output core_pkg::xdata_t    result_value_o,
	output logic                illegal_o
);
	import core_pkg::*;

	decoded_t  dec;
	issue_t    iss;
	wb_t       alu_fwd;
	wb_t       wb;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	xdata_t    rs1_data;
	xdata_t    rs2_data;

	inst_decoder inst_decoder_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.dec_o        (dec)
	);

	reg_file reg_file_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wb_i       (wb)
	);

	operand_stage operand_stage_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.dec_i      (dec),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.alu_fwd_i  (alu_fwd),
		.wb_fwd_i   (wb),
		.iss_o      (iss)
	);

	alu alu_inst (
		.clk     (clk),
		.reset_i (reset_i),
		.iss_i   (iss),
		.fwd_o   (alu_fwd),
		.wb_o    (wb)
	);

	// results leave straight from the writeback register
	assign result_valid_o = wb.valid;
	assign result_rd_o = wb.rd;
	assign result_value_o = wb.value;
	assign illegal_o = wb.illegal;

endmodule

// File: src/operand_stage.sv
`timescale 1ns/1ns

module operand_stage (
	input  logic                clk,
	input  logic                reset_i,
	input  core_pkg::decoded_t  dec_i,
	output core_pkg::reg_addr_t rs1_addr_o,
	output core_pkg::reg_addr_t rs2_addr_o,
	input  core_pkg::xdata_t    rs1_data_i,
	input  core_pkg::xdata_t    rs2_data_i,
	input  core_pkg::wb_t       alu_fwd_i,
	input  core_pkg::wb_t       wb_fwd_i,
	output core_pkg::issue_t    iss_o
);
	import core_pkg::*;

	xdata_t rs1_val;
	xdata_t rs2_val;
	issue_t iss_d;

	// youngest producer wins, then the one behind it, then the regfile
	function automatic xdata_t pick_src(
		input reg_addr_t addr,
		input xdata_t    rf_data,
		input wb_t       ex,
		input wb_t       wb
	);
		xdata_t val;
		if (addr == '0) begin
			val = '0;
		end else if (ex.valid && ex.rd_we && ex.rd == addr) begin
			val = ex.value;
		end else if (wb.valid && wb.rd_we && wb.rd == addr) begin
			val = wb.value;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	assign rs1_addr_o = dec_i.rs1;
	assign rs2_addr_o = dec_i.rs2;

	assign rs1_val = pick_src(dec_i.rs1, rs1_data_i, alu_fwd_i, wb_fwd_i);
	assign rs2_val = pick_src(dec_i.rs2, rs2_data_i, alu_fwd_i, wb_fwd_i);

	always_comb begin
		iss_d.valid = dec_i.valid;
		iss_d.op_a = rs1_val;
		iss_d.op_b = dec_i.use_imm ? dec_i.imm : rs2_val;
		iss_d.alu_op = dec_i.alu_op;
		iss_d.rd = dec_i.rd;
		iss_d.rd_we = dec_i.rd_we;
		iss_d.illegal = dec_i.illegal;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			iss_o.valid <= 1'b0;
			iss_o.rd_we <= 1'b0;
			iss_o.illegal <= 1'b0;
		end else begin
			iss_o <= iss_d;
		end
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic                clk,
	input  logic                reset_i,
	input  core_pkg::reg_addr_t rs1_addr_i,
	input  core_pkg::reg_addr_t rs2_addr_i,
	output core_pkg::xdata_t    rs1_data_o,
	output core_pkg::xdata_t    rs2_data_o,
	input  core_pkg::wb_t       wb_i
);
	import core_pkg::*;

	// x0 has no storage
	xdata_t regs [1:31];
	logic   wr_en;

	assign wr_en = wb_i.valid && wb_i.rd_we && (wb_i.rd != '0);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_i.rd] <= wb_i.value;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// illegal results never reach a register
	assert property (@(posedge clk) disable iff (reset_i)
		wr_en |-> !wb_i.illegal);

endmodule

// File: testbench/tb_int_core.sv
`timescale 1ns/1ns

module tb_int_core;
	import core_pkg::*;

	localparam int TIMEOUT_CYCLES = 2500;

	typedef struct packed {
		int        cycle;
		reg_addr_t rd;
		xdata_t    value;
		logic      illegal;
	} expect_t;

	logic      clk;
	logic      reset_i;
	logic      inst_valid_i;
	inst_t     inst_i;
	logic      result_valid_o;
	reg_addr_t result_rd_o;
	xdata_t    result_value_o;
	logic      illegal_o;

	xdata_t  model_regs [32];
	expect_t exp_q [$];
	expect_t exp_cur;
	logic    exp_valid = 1'b0;
	int      cyc = 0;

	int_core int_core_inst (
		.clk            (clk),
		.reset_i        (reset_i),
		.inst_valid_i   (inst_valid_i),
		.inst_i         (inst_i),
		.result_valid_o (result_valid_o),
		.result_rd_o    (result_rd_o),
		.result_value_o (result_value_o),
		.illegal_o      (illegal_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == TIMEOUT_CYCLES) begin
			$display("TEST FAILED");
			$fatal(1, "timeout: results still pending after %0d cycles", TIMEOUT_CYCLES);
		end
	end

	// a strobe sampled at cycle c shows up after edge c+3
	always @(posedge clk) begin
		expect_t head;
		if (exp_q.size() != 0 && exp_q[0].cycle + 3 == cyc) begin
			head = exp_q.pop_front();
			exp_cur <= head;
			exp_valid <= 1'b1;
		end else begin
			exp_valid <= 1'b0;
		end
	end

	task automatic report_mismatch(input string sig, input xdata_t exp, input xdata_t act);
		$display("ERR %0t ns %s expected %h got %h", $time, sig, exp, act);
		$display("TEST FAILED");
		$fatal(1, "result mismatch on %s", sig);
	endtask

	// outputs only move on the rising edge, so compare on the falling one
	valid_check: assert property (@(negedge clk) result_valid_o == exp_valid)
		else report_mismatch("result_valid_o", exp_valid, result_valid_o);
	illegal_check: assert property (@(negedge clk) illegal_o == (exp_valid && exp_cur.illegal))
		else report_mismatch("illegal_o", exp_valid && exp_cur.illegal, illegal_o);
	rd_check: assert property (@(negedge clk) exp_valid |-> result_rd_o == exp_cur.rd)
		else report_mismatch("result_rd_o", exp_cur.rd, result_rd_o);
	value_check: assert property (@(negedge clk) exp_valid |-> result_value_o == exp_cur.value)
		else report_mismatch("result_value_o", exp_cur.value, result_value_o);

	// kinds 0..9 register form, 10..18 immediate form (8 is sub, 9 sra, 18 srai)
	function automatic inst_t encode(input int kind, input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2, input logic [11:0] imm);
		logic       is_imm;
		int         k;
		logic       alt;
		logic [2:0] f3;
		logic [6:0] hi;
		logic [4:0] lo;
		is_imm = (kind >= 10);
		k = is_imm ? kind - 10 : kind;
		alt = (k >= 8);
		f3 = !alt ? 3'(k) : (is_imm || k == 9) ? 3'd5 : 3'd0;
		hi = !is_imm ? {1'b0, alt, 5'b0} :
			(f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 4'b0, imm[5]} : imm[11:5];
		lo = is_imm ? imm[4:0] : rs2;
		return {hi, lo, rs1, f3, rd, is_imm ? OPC_OP_IMM : OPC_OP};
	endfunction

	function automatic inst_t encode_bad(input int kind, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2, input logic [11:0] imm);
		case (kind % 5)
			0: return encode(0, rd, rs1, rs2, imm) | 32'h0200_0000;
			1: return (encode(10, rd, rs1, rs2, imm) & ~32'h7f) | 32'h03;
			2: return encode(4, rd, rs1, rs2, imm) | 32'h4000_0000;
			3: return encode(11, rd, rs1, rs2, imm) | 32'h4000_0000;
			default: return encode(18, rd, rs1, rs2, imm) | 32'h0400_0000;
		endcase
	endfunction

	function automatic void model_exec(input inst_t w, output logic bad, output xdata_t val);
		logic [6:0] opc;
		logic [2:0] f3;
		xdata_t     a;
		xdata_t     b;
		logic [5:0] sh;
		opc = w[6:0];
		f3 = w[14:12];
		a = model_regs[w[19:15]];
		b = (opc == OPC_OP_IMM) ? {{52{w[31]}}, w[31:20]} : model_regs[w[24:20]];
		sh = b[5:0];
		if (opc == OPC_OP) begin
			bad = !(w[31:25] == 7'h00 || (w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
		end else if (opc == OPC_OP_IMM && (f3 == 3'd1 || f3 == 3'd5)) begin
			bad = !(w[31:26] == 6'h00 || (w[31:26] == 6'h10 && f3 == 3'd5));
		end else begin
			bad = (opc != OPC_OP_IMM);
		end
		case (f3)
			3'd0: val = (opc == OPC_OP && w[30]) ? a - b : a + b;
			3'd1: val = a << sh;
			3'd2: val = xdata_t'($signed(a) < $signed(b));
			3'd3: val = xdata_t'(a < b);
			3'd4: val = a ^ b;
			// fill the vacated top bits with the sign for sra
			3'd5: val = (a >> sh) | ((w[30] && a[63]) ? ~(~xdata_t'(0) >> sh) : xdata_t'(0));
			3'd6: val = a | b;
			default: val = a & b;
		endcase
		if (bad) begin
			val = '0;
		end else if (w[11:7] != 5'd0) begin
			model_regs[w[11:7]] = val;
		end
	endfunction

	task automatic send(input inst_t w, input int gap);
		logic   bad;
		xdata_t val;
		@(negedge clk);
		inst_valid_i = 1'b1;
		inst_i = w;
		model_exec(w, bad, val);
		exp_q.push_back(expect_t'{cycle: cyc, rd: w[11:7], value: val, illegal: bad});
		repeat (gap) begin
			@(negedge clk);
			inst_valid_i = 1'b0;
		end
	endtask

	initial begin
		reg_addr_t rd;
		reg_addr_t prev;
		void'($urandom(8551));
		reset_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		// untouched registers read zero
		send(encode(0, 5'd5, 5'd1, 5'd2, 12'd0), 0);
		// fill every register with a wide random value
		for (int r = 1; r < 32; r++) begin
			send(encode(10, 5'(r), 5'd0, 5'd0, 12'($urandom)), 0);
			send(encode(11, 5'(r), 5'(r), 5'd0, 12'($urandom)), 0);
			send(encode(14, 5'(r), 5'(r), 5'd0, 12'($urandom)), 0);
		end
		for (int k = 0; k < 19; k++) begin
			send(encode(k, 5'($urandom_range(31, 1)), 5'($urandom), 5'($urandom),
				12'($urandom)), 0);
		end
		// dependent chains at each spacing
		for (int gap = 0; gap < 3; gap++) begin
			prev = 5'($urandom_range(31, 1));
			for (int i = 0; i < 6; i++) begin
				rd = 5'($urandom_range(31, 1));
				send(encode($urandom % 19, rd, prev, 5'($urandom), 12'($urandom)), gap);
				prev = rd;
			end
		end
		// x0 reports its value but keeps zero
		send(encode(0, 5'd0, 5'd3, 5'd4, 12'd0), 0);
		send(encode(0, 5'd6, 5'd0, 5'd0, 12'd0), 0);
		for (int k = 0; k < 5; k++) begin
			rd = 5'($urandom_range(31, 1));
			send(encode_bad(k, rd, 5'($urandom), 5'($urandom), 12'($urandom)), 0);
			send(encode(0, 5'($urandom_range(31, 1)), rd, 5'd0, 12'd0), $urandom % 3);
		end
		prev = 5'd1;
		for (int n = 0; n < 480; n++) begin
			rd = 5'($urandom);
			if ($urandom % 16 == 0) begin
				send(encode_bad($urandom % 5, rd, 5'($urandom), 5'($urandom), 12'($urandom)),
					$urandom % 3);
			end else begin
				send(encode($urandom % 19, rd, ($urandom % 2) ? prev : 5'($urandom),
					5'($urandom), 12'($urandom)), $urandom % 3);
			end
			prev = rd;
		end
		@(negedge clk);
		inst_valid_i = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

// File: verilog.f
src/core_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_stage.sv
src/alu.sv
src/int_core.sv
testbench/tb_int_core.sv
